// File: include/tso_config.svh
// flits must be at least 64 bytes so the whole 42 byte header sits in the first flit
`ifndef TSO_CONFIG_SVH
`define TSO_CONFIG_SVH

// stream geometry
`define TSO_FLIT_BYTES      64

// header sizes in bytes
`define TSO_ETH_HDR         14
`define TSO_IP_HDR          20
`define TSO_UDP_HDR         8
`define TSO_HDR_BYTES       (`TSO_ETH_HDR + `TSO_IP_HDR + `TSO_UDP_HDR)

// IP total length of the first split frame
`define TSO_SEG_LEN         800

// checksum command fields
`define TSO_CSUM_START      34
`define TSO_CSUM_OFF_TCP    50
`define TSO_CSUM_OFF_OTHER  40

// classification values
`define TSO_ETHERTYPE_IPV4  16'h0800
`define TSO_PROTO_TCP       8'd6
`define TSO_PROTO_UDP       8'd17

`endif

// File: logic/tso_pkg.sv
// byte i of a flit is data[8i+7:8i]; keep is low ones on the last flit, full elsewhere
`include "tso_config.svh"

package tso_pkg;

    // one bus beat of the frame stream
    typedef struct packed {
        logic [8*`TSO_FLIT_BYTES-1:0] data;
        logic [`TSO_FLIT_BYTES-1:0]   keep;
        logic                         last;
    } flit_t;

    // decided from the first flit of a frame
    typedef enum logic [1:0] {
        CLS_PASS,       // forwarded as is, no checksum
        CLS_TCP,        // forwarded as is, checksum enabled
        CLS_UDP_SPLIT   // split into two frames
    } pkt_class_t;

    // rewritten headers for both halves of a split frame
    typedef struct packed {
        logic [8*`TSO_HDR_BYTES-1:0] hdr_first;
        logic [8*`TSO_HDR_BYTES-1:0] hdr_second;
        logic [15:0]                 second_len;  // IP total length, second frame
    } seg_hdr_t;

    // request for the downstream checksum unit
    typedef struct packed {
        logic       enable;
        logic [7:0] start;
        logic [7:0] offset;
    } csum_cmd_t;

endpackage

// File: logic/hdr_classify.sv
// purely combinational; only meaningful while first_flit holds the first flit of a frame
`timescale 1ns/1ps
`include "tso_config.svh"

module hdr_classify (
    input  tso_pkg::flit_t      first_flit,
    output tso_pkg::pkt_class_t pkt_class,
    output tso_pkg::seg_hdr_t   seg_hdr
);

    localparam int HDR_BITS     = 8 * `TSO_HDR_BYTES;
    localparam int OFS_ETYPE    = `TSO_ETH_HDR - 2;
    localparam int OFS_IP_LEN   = `TSO_ETH_HDR + 2;
    localparam int OFS_PROTO    = `TSO_ETH_HDR + 9;
    localparam int OFS_IP_CSUM  = `TSO_ETH_HDR + 10;
    localparam int OFS_UDP_LEN  = `TSO_ETH_HDR + `TSO_IP_HDR + 4;
    localparam int OFS_UDP_CSUM = `TSO_ETH_HDR + `TSO_IP_HDR + 6;

    logic [15:0]         ethertype;
    logic [7:0]          ip_proto;
    logic [15:0]         ip_len;
    logic [15:0]         ip_csum;
    logic [15:0]         second_len;
    logic [HDR_BITS-1:0] hdr_first;
    logic [HDR_BITS-1:0] hdr_second;

    // one's complement update, RFC 1624 eqn 3
    function automatic logic [15:0] csum_update(input logic [15:0] hc,
                                                input logic [15:0] m_old,
                                                input logic [15:0] m_new);
        logic [17:0] sum;
        sum = {2'b00, ~hc} + {2'b00, ~m_old} + {2'b00, m_new};
        sum = {2'b00, sum[15:0]} + {16'd0, sum[17:16]};  // end around carry
        sum = {2'b00, sum[15:0]} + {16'd0, sum[17:16]};
        return ~sum[15:0];
    endfunction

    // network order 16 bit field write
    function automatic logic [HDR_BITS-1:0] put16(input logic [HDR_BITS-1:0] hdr,
                                                  input int ofs, input logic [15:0] val);
        logic [HDR_BITS-1:0] res;
        res = hdr;
        res[ofs*8 +: 8]     = val[15:8];
        res[ofs*8 + 8 +: 8] = val[7:0];
        return res;
    endfunction

    assign ethertype  = {first_flit.data[OFS_ETYPE*8 +: 8], first_flit.data[OFS_ETYPE*8 + 8 +: 8]};
    assign ip_proto   = first_flit.data[OFS_PROTO*8 +: 8];
    assign ip_len     = {first_flit.data[OFS_IP_LEN*8 +: 8], first_flit.data[OFS_IP_LEN*8 + 8 +: 8]};
    assign ip_csum    = {first_flit.data[OFS_IP_CSUM*8 +: 8],
                         first_flit.data[OFS_IP_CSUM*8 + 8 +: 8]};
    assign second_len = ip_len - 16'(`TSO_SEG_LEN) + 16'(`TSO_IP_HDR + `TSO_UDP_HDR);

    always_comb begin
        pkt_class = tso_pkg::CLS_PASS;  // single flit frames always pass
        if (!first_flit.last && ethertype == `TSO_ETHERTYPE_IPV4) begin
            if (ip_proto == `TSO_PROTO_TCP) begin
                pkt_class = tso_pkg::CLS_TCP;
            end else if (ip_proto == `TSO_PROTO_UDP && ip_len > 16'(`TSO_SEG_LEN)) begin
                pkt_class = tso_pkg::CLS_UDP_SPLIT;
            end
        end
    end

    always_comb begin
        hdr_first  = first_flit.data[0 +: HDR_BITS];
        hdr_first  = put16(hdr_first, OFS_IP_LEN, 16'(`TSO_SEG_LEN));
        hdr_first  = put16(hdr_first, OFS_IP_CSUM, csum_update(ip_csum, ip_len, 16'(`TSO_SEG_LEN)));
        hdr_first  = put16(hdr_first, OFS_UDP_LEN, 16'(`TSO_SEG_LEN - `TSO_IP_HDR));
        hdr_first  = put16(hdr_first, OFS_UDP_CSUM, 16'd0);
        hdr_second = first_flit.data[0 +: HDR_BITS];
        hdr_second = put16(hdr_second, OFS_IP_LEN, second_len);
        hdr_second = put16(hdr_second, OFS_IP_CSUM, csum_update(ip_csum, ip_len, second_len));
        hdr_second = put16(hdr_second, OFS_UDP_LEN, second_len - 16'(`TSO_IP_HDR));
        hdr_second = put16(hdr_second, OFS_UDP_CSUM, 16'd0);
    end

    assign seg_hdr = '{hdr_first: hdr_first, hdr_second: hdr_second, second_len: second_len};

endmodule

// File: logic/seg_engine.sv
// at most two segments; needs full keep on all but the last input flit and a split point inside a flit
`timescale 1ns/1ps
`include "tso_config.svh"

module seg_engine (
    input  logic                clk,
    input  logic                rst,
    input  tso_pkg::flit_t      s_flit,
    input  logic                s_valid,
    output logic                s_ready,
    output tso_pkg::flit_t      hdr_flit,
    input  tso_pkg::pkt_class_t pkt_class,
    input  tso_pkg::seg_hdr_t   seg_hdr,
    output tso_pkg::flit_t      o_flit,
    output logic                o_valid,
    input  logic                o_ready,
    output tso_pkg::csum_cmd_t  o_cmd,
    output logic                o_cmd_valid,
    input  logic                o_cmd_ready
);

    localparam int FLIT        = `TSO_FLIT_BYTES;
    localparam int HDR         = `TSO_HDR_BYTES;
    localparam int SPLIT_AT    = `TSO_ETH_HDR + `TSO_SEG_LEN;  // first byte of segment two
    localparam int TAIL_LEN    = SPLIT_AT % FLIT;              // bytes of tail flit kept in seg one
    localparam int TAIL_REMAIN = FLIT - TAIL_LEN;              // tail bytes moved to seg two
    localparam int SHIFT       = TAIL_LEN - HDR;               // body realignment in bytes

    typedef enum logic [2:0] {
        ST_IDLE, ST_PASS, ST_FIRST, ST_SHDR, ST_BODY, ST_DRAIN
    } state_t;

    state_t               state;
    logic                 run_q;
    logic [15:0]          remain;   // bytes left in the first segment
    logic [8*HDR-1:0]     hdr2_q;
    tso_pkg::flit_t       tail_q;
    tso_pkg::flit_t       prev_q;
    logic                 take_in;
    logic                 need_cmd;
    logic                 has_out;
    logic                 out_ok;
    logic                 step;

    assign hdr_flit = s_flit;  // classifier looks at the current flit, used in idle only

    always_comb begin
        case (state)
            ST_SHDR:  take_in = !tail_q.last;  // short second frame fits without new input
            ST_DRAIN: take_in = 1'b0;
            default:  take_in = 1'b1;
        endcase
    end

    // a command goes with the first flit of every output frame
    assign need_cmd    = (state == ST_IDLE) || (state == ST_SHDR);
    assign has_out     = run_q && (s_valid || !take_in);
    assign out_ok      = o_ready && (o_cmd_ready || !need_cmd);
    assign step        = has_out && out_ok;
    assign s_ready     = run_q && take_in && out_ok;
    assign o_valid     = has_out && (o_cmd_ready || !need_cmd);
    assign o_cmd_valid = has_out && need_cmd && o_ready;

    always_comb begin
        o_flit       = s_flit;
        o_cmd.enable = 1'b0;
        o_cmd.start  = 8'(`TSO_CSUM_START);
        o_cmd.offset = 8'(`TSO_CSUM_OFF_OTHER);
        case (state)
            ST_IDLE: begin
                if (pkt_class == tso_pkg::CLS_TCP) begin
                    o_cmd.enable = 1'b1;
                    o_cmd.offset = 8'(`TSO_CSUM_OFF_TCP);
                end
                if (pkt_class == tso_pkg::CLS_UDP_SPLIT) begin
                    o_flit.data[0 +: 8*HDR] = seg_hdr.hdr_first;
                end
            end
            ST_FIRST: begin
                if (remain <= 16'(FLIT)) begin  // tail flit, cut at the split point
                    o_flit.keep = {FLIT{1'b1}} >> (16'(FLIT) - remain);
                    o_flit.last = 1'b1;
                end
            end
            ST_SHDR: begin
                if (tail_q.last) begin
                    o_flit.data = {{8*SHIFT{1'b0}}, tail_q.data[8*TAIL_LEN +: 8*TAIL_REMAIN],
                                   hdr2_q};
                    o_flit.keep = {{SHIFT{1'b0}}, tail_q.keep[FLIT-1:TAIL_LEN], {HDR{1'b1}}};
                    o_flit.last = 1'b1;
                end else begin
                    o_flit.data = {s_flit.data[0 +: 8*SHIFT],
                                   tail_q.data[8*TAIL_LEN +: 8*TAIL_REMAIN], hdr2_q};
                    o_flit.keep = {s_flit.keep[SHIFT-1:0], {(HDR + TAIL_REMAIN){1'b1}}};
                    o_flit.last = s_flit.last && !s_flit.keep[SHIFT];
                end
            end
            ST_BODY: begin
                o_flit.data = {s_flit.data[0 +: 8*SHIFT], prev_q.data[8*FLIT-1:8*SHIFT]};
                o_flit.keep = {s_flit.keep[SHIFT-1:0], prev_q.keep[FLIT-1:SHIFT]};
                o_flit.last = s_flit.last && !s_flit.keep[SHIFT];  // rest fits in this flit
            end
            ST_DRAIN: begin
                o_flit.data = prev_q.data >> (8*SHIFT);
                o_flit.keep = prev_q.keep >> SHIFT;
                o_flit.last = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_IDLE;
            run_q  <= 1'b0;
            remain <= '0;
        end else begin
            run_q <= 1'b1;
            if (step) begin
                case (state)
                    ST_IDLE: begin
                        if (pkt_class == tso_pkg::CLS_UDP_SPLIT) begin
                            state  <= ST_FIRST;
                            remain <= 16'(SPLIT_AT - FLIT);
                        end else if (!s_flit.last) begin
                            state <= ST_PASS;
                        end
                    end
                    ST_PASS: begin
                        if (s_flit.last) state <= ST_IDLE;
                    end
                    ST_FIRST: begin
                        if (remain <= 16'(FLIT)) begin
                            state <= ST_SHDR;
                        end else begin
                            remain <= remain - 16'(FLIT);
                        end
                    end
                    ST_SHDR, ST_BODY: begin
                        if (state == ST_SHDR && tail_q.last) begin
                            state <= ST_IDLE;
                        end else if (s_flit.last) begin
                            state <= s_flit.keep[SHIFT] ? ST_DRAIN : ST_IDLE;
                        end else begin
                            state <= ST_BODY;
                        end
                    end
                    default: state <= ST_IDLE;  // drain done
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step) begin
            if (state == ST_IDLE) hdr2_q <= seg_hdr.hdr_second;
            if (state == ST_FIRST) tail_q <= s_flit;
            if (state == ST_SHDR || state == ST_BODY) prev_q <= s_flit;
        end
    end

endmodule

// File: logic/stream_reg.sv
// one entry; full throughput only while the sink keeps ready high
`timescale 1ns/1ps

module stream_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    // free when empty or when the held entry leaves this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;  // held until accepted
        end
    end

endmodule

// File: logic/udp_seg_offload.sv
// splits long UDP frames in two; the host keeps IP total length within two segments minus 28
`timescale 1ns/1ps

module udp_seg_offload (
    input  logic               clk,
    input  logic               rst,
    input  tso_pkg::flit_t     s_flit,
    input  logic               s_valid,
    output logic               s_ready,
    output tso_pkg::flit_t     m_flit,
    output logic               m_valid,
    input  logic               m_ready,
    output tso_pkg::csum_cmd_t m_cmd,
    output logic               m_cmd_valid,
    input  logic               m_cmd_ready
);

    tso_pkg::flit_t      hdr_flit;
    tso_pkg::pkt_class_t pkt_class;
    tso_pkg::seg_hdr_t   seg_hdr;
    tso_pkg::flit_t      eng_flit;
    logic                eng_valid;
    logic                eng_ready;
    tso_pkg::csum_cmd_t  eng_cmd;
    logic                eng_cmd_valid;
    logic                eng_cmd_ready;

    hdr_classify u_hdr_classify (
        .first_flit (hdr_flit),
        .pkt_class  (pkt_class),
        .seg_hdr    (seg_hdr)
    );

    seg_engine u_seg_engine (
        .clk         (clk),
        .rst         (rst),
        .s_flit      (s_flit),
        .s_valid     (s_valid),
        .s_ready     (s_ready),
        .hdr_flit    (hdr_flit),
        .pkt_class   (pkt_class),
        .seg_hdr     (seg_hdr),
        .o_flit      (eng_flit),
        .o_valid     (eng_valid),
        .o_ready     (eng_ready),
        .o_cmd       (eng_cmd),
        .o_cmd_valid (eng_cmd_valid),
        .o_cmd_ready (eng_cmd_ready)
    );

    stream_reg #(.payload_t(tso_pkg::flit_t)) u_flit_reg (
        .clk       (clk),
        .rst       (rst),
        .in_data   (eng_flit),
        .in_valid  (eng_valid),
        .in_ready  (eng_ready),
        .out_data  (m_flit),
        .out_valid (m_valid),
        .out_ready (m_ready)
    );

    stream_reg #(.payload_t(tso_pkg::csum_cmd_t)) u_cmd_reg (
        .clk       (clk),
        .rst       (rst),
        .in_data   (eng_cmd),
        .in_valid  (eng_cmd_valid),
        .in_ready  (eng_cmd_ready),
        .out_data  (m_cmd),
        .out_valid (m_cmd_valid),
        .out_ready (m_cmd_ready)
    );

endmodule

// File: tests/tb_clock.sv
// free running 8 ns clock; rst is synchronous and drops 1 ns after the tenth rising edge
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// File: tests/tso_model.svh
// included inside the testbench module; fills its exp_flits and exp_cmds from one input frame
`ifndef TSO_MODEL_SVH
`define TSO_MODEL_SVH

typedef logic [7:0] bytes_t[$];
typedef tso_pkg::flit_t flits_t[$];

// incremental update of a one's complement checksum when one 16 bit word changes
function automatic logic [15:0] csum_adjust(input logic [15:0] hc, input logic [15:0] old_v,
                                            input logic [15:0] new_v);
    logic [31:0] s;
    s = {16'd0, ~hc} + {16'd0, ~old_v} + {16'd0, new_v};
    while (s > 32'hffff) begin
        s = (s & 32'hffff) + (s >> 16);  // fold carries back in
    end
    return ~s[15:0];
endfunction

function automatic bytes_t set16(input bytes_t fr, input int ofs, input logic [15:0] v);
    bytes_t r;
    r = fr;
    r[ofs]     = v[15:8];  // network order
    r[ofs + 1] = v[7:0];
    return r;
endfunction

// byte frame to flits with low keep bits on the last one
function automatic flits_t to_flits(input bytes_t fr);
    flits_t         q;
    tso_pkg::flit_t f;
    int             i;
    int             b;
    for (i = 0; i < fr.size(); i += `TSO_FLIT_BYTES) begin
        f = '0;
        for (b = 0; b < `TSO_FLIT_BYTES && i + b < fr.size(); b++) begin
            f.data[8*b +: 8] = fr[i + b];
            f.keep[b] = 1'b1;
        end
        f.last = (i + `TSO_FLIT_BYTES >= fr.size());
        q.push_back(f);
    end
    return q;
endfunction

function automatic void expect_frame(input bytes_t fr, input tso_pkg::csum_cmd_t cmd);
    flits_t q;
    q = to_flits(fr);
    foreach (q[i]) exp_flits.push_back(q[i]);
    exp_cmds.push_back(cmd);
endfunction

function automatic void model_frame(input bytes_t fr);
    bytes_t             seg1;
    bytes_t             seg2;
    logic [15:0]        etype;
    logic [7:0]         proto;
    logic [15:0]        len;
    logic [15:0]        csum;
    logic [15:0]        len2;
    int                 i;
    tso_pkg::csum_cmd_t cmd;
    etype = {fr[12], fr[13]};
    proto = fr[`TSO_ETH_HDR + 9];
    len   = {fr[`TSO_ETH_HDR + 2], fr[`TSO_ETH_HDR + 3]};
    csum  = {fr[`TSO_ETH_HDR + 10], fr[`TSO_ETH_HDR + 11]};
    cmd   = '{enable: 1'b0, start: 8'(`TSO_CSUM_START), offset: 8'(`TSO_CSUM_OFF_OTHER)};
    if (fr.size() <= `TSO_FLIT_BYTES || etype != `TSO_ETHERTYPE_IPV4) begin
        expect_frame(fr, cmd);
    end else if (proto == `TSO_PROTO_TCP) begin
        cmd.enable = 1'b1;
        cmd.offset = 8'(`TSO_CSUM_OFF_TCP);
        expect_frame(fr, cmd);
    end else if (proto != `TSO_PROTO_UDP || len <= 16'(`TSO_SEG_LEN)) begin
        expect_frame(fr, cmd);
    end else begin
        len2 = len - 16'(`TSO_SEG_LEN) + 16'(`TSO_IP_HDR + `TSO_UDP_HDR);
        for (i = 0; i < `TSO_ETH_HDR + `TSO_SEG_LEN; i++) seg1.push_back(fr[i]);
        for (i = 0; i < `TSO_HDR_BYTES; i++) seg2.push_back(fr[i]);
        for (i = `TSO_ETH_HDR + `TSO_SEG_LEN; i < fr.size(); i++) seg2.push_back(fr[i]);
        seg1 = set16(seg1, 16, 16'(`TSO_SEG_LEN));
        seg1 = set16(seg1, 24, csum_adjust(csum, len, 16'(`TSO_SEG_LEN)));
        seg1 = set16(seg1, 38, 16'(`TSO_SEG_LEN - `TSO_IP_HDR));
        seg1 = set16(seg1, 40, 16'd0);
        seg2 = set16(seg2, 16, len2);
        seg2 = set16(seg2, 24, csum_adjust(csum, len, len2));
        seg2 = set16(seg2, 38, len2 - 16'(`TSO_IP_HDR));
        seg2 = set16(seg2, 40, 16'd0);  // udp checksum left to later stage
        expect_frame(seg1, cmd);
        expect_frame(seg2, cmd);
    end
endfunction

`endif

// File: tests/tb_udp_seg.sv
// random frames from seed 10; long UDP lengths stay within two segments minus 28
`timescale 1ns/1ps
`include "tso_config.svh"

module tb_udp_seg;

    localparam int TIMEOUT = 2000;  // cycles allowed per wait

    logic               clk;
    logic               rst;
    tso_pkg::flit_t     s_flit;
    logic               s_valid;
    logic               s_ready;
    tso_pkg::flit_t     m_flit;
    logic               m_valid;
    logic               m_ready;
    tso_pkg::csum_cmd_t m_cmd;
    logic               m_cmd_valid;
    logic               m_cmd_ready;

    tso_pkg::flit_t     exp_flits[$];
    tso_pkg::csum_cmd_t exp_cmds[$];
    int                 errors;
    int                 tests_run;
    int                 tests_failed;
    bit                 back_pressure;

    `include "tso_model.svh"

    tb_clock u_tb_clock (
        .clk (clk),
        .rst (rst)
    );

    udp_seg_offload u_udp_seg_offload (
        .clk         (clk),
        .rst         (rst),
        .s_flit      (s_flit),
        .s_valid     (s_valid),
        .s_ready     (s_ready),
        .m_flit      (m_flit),
        .m_valid     (m_valid),
        .m_ready     (m_ready),
        .m_cmd       (m_cmd),
        .m_cmd_valid (m_cmd_valid),
        .m_cmd_ready (m_cmd_ready)
    );

    // sink readiness goes random while back_pressure is set
    initial begin
        m_ready     = 1'b0;
        m_cmd_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            m_ready     = !back_pressure || ($urandom_range(0, 3) != 0);
            m_cmd_ready = !back_pressure || ($urandom_range(0, 2) != 0);
        end
    end

    // kind 0 single flit, 1 non-IPv4, 2 TCP, 3 short UDP, 4 ICMP, 5 long UDP
    function automatic bytes_t make_frame(input int kind);
        bytes_t fr;
        int     n;
        int     i;
        case (kind)
            0: n = $urandom_range(`TSO_HDR_BYTES, `TSO_FLIT_BYTES);
            3: n = $urandom_range(`TSO_FLIT_BYTES + 1, `TSO_ETH_HDR + `TSO_SEG_LEN);
            5: begin
                if ($urandom_range(0, 1) != 0) begin  // short second frame near the split
                    n = $urandom_range(`TSO_ETH_HDR + `TSO_SEG_LEN + 1,
                                       `TSO_ETH_HDR + `TSO_SEG_LEN + 24);
                end else begin
                    n = $urandom_range(`TSO_ETH_HDR + `TSO_SEG_LEN + 1,
                                       `TSO_ETH_HDR + 2 * `TSO_SEG_LEN - 28);
                end
            end
            default: n = $urandom_range(`TSO_FLIT_BYTES + 1, 400);
        endcase
        for (i = 0; i < n; i++) fr.push_back(8'($urandom));
        fr[12] = (kind == 1) ? 8'h86 : 8'h08;  // IPv6 ethertype for the non-IPv4 case
        fr[13] = (kind == 1) ? 8'hdd : 8'h00;
        fr[14] = 8'h45;
        fr[16] = 8'((n - `TSO_ETH_HDR) >> 8);
        fr[17] = 8'(n - `TSO_ETH_HDR);
        case (kind)
            0, 2: fr[23] = `TSO_PROTO_TCP;  // single flit TCP still gets no checksum
            4: fr[23] = 8'd1;
            default: fr[23] = `TSO_PROTO_UDP;
        endcase
        return fr;
    endfunction

    task automatic check_flit(input tso_pkg::flit_t got, input tso_pkg::flit_t want,
                              input int idx);
        logic [8*`TSO_FLIT_BYTES-1:0] mask;
        int                           b;
        for (b = 0; b < `TSO_FLIT_BYTES; b++) mask[8*b +: 8] = {8{want.keep[b]}};
        if (got.keep !== want.keep || got.last !== want.last ||
            ((got.data ^ want.data) & mask) != '0) begin
            $display("Error at time %0t: flit %0d wrong, keep %h last %b, expected keep %h last %b",
                     $time, idx, got.keep, got.last, want.keep, want.last);
            errors++;
        end
    endtask

    task automatic check_cmd(input tso_pkg::csum_cmd_t got, input tso_pkg::csum_cmd_t want,
                             input int idx);
        if (got !== want) begin
            $display("Error at time %0t: command %0d is %b/%0d/%0d, expected %b/%0d/%0d",
                     $time, idx, got.enable, got.start, got.offset,
                     want.enable, want.start, want.offset);
            errors++;
        end
    endtask

    // each flit held until the DUT takes it
    task automatic send_flits(input flits_t q);
        int i;
        int wait_n;
        bit ok;
        ok = 1'b1;
        @(posedge clk);
        #1;
        for (i = 0; i < q.size() && ok; i++) begin
            s_flit  = q[i];
            s_valid = 1'b1;
            wait_n  = 0;
            do begin
                @(negedge clk);
                wait_n++;
            end while (!s_ready && wait_n < TIMEOUT);
            ok = s_ready;
            @(posedge clk);
            #1;
        end
        s_valid = 1'b0;
        if (!ok) begin
            $display("input stalled: flit %0d was not accepted in %0d cycles", i - 1, TIMEOUT);
            errors++;
        end
    endtask

    task automatic collect_flits(input int n);
        int got;
        int idle;
        got  = 0;
        idle = 0;
        while (got < n && idle < TIMEOUT) begin
            @(negedge clk);
            if (m_valid && m_ready) begin  // transfer on the next rising edge
                check_flit(m_flit, exp_flits.pop_front(), got);
                got++;
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (got < n) begin
            $display("output stalled: only %0d of %0d flits arrived", got, n);
            errors++;
        end
    endtask

    task automatic collect_cmds(input int n);
        int got;
        int idle;
        got  = 0;
        idle = 0;
        while (got < n && idle < TIMEOUT) begin
            @(negedge clk);
            if (m_cmd_valid && m_cmd_ready) begin
                check_cmd(m_cmd, exp_cmds.pop_front(), got);
                got++;
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (got < n) begin
            $display("command stream stalled: only %0d of %0d commands arrived", got, n);
            errors++;
        end
    endtask

    task automatic run_test(input string name, input int lo, input int hi, input int count,
                            input bit bp);
        flits_t in_q;
        flits_t fq;
        bytes_t fr;
        int     k;
        int     err0;
        int     nf;
        int     nc;
        err0          = errors;
        back_pressure = bp;
        exp_flits.delete();
        exp_cmds.delete();
        for (k = 0; k < count; k++) begin
            fr = make_frame($urandom_range(lo, hi));
            model_frame(fr);
            fq = to_flits(fr);
            foreach (fq[j]) in_q.push_back(fq[j]);
        end
        nf = exp_flits.size();
        nc = exp_cmds.size();
        fork
            send_flits(in_q);
            collect_flits(nf);
            collect_cmds(nc);
        join
        tests_run++;
        if (errors != err0) tests_failed++;
        $display("test %0d %s: %s, %0d frames in, %0d flits and %0d commands out", tests_run,
                 name, (errors == err0) ? "ok" : "failed", count, nf, nc);
    endtask

    initial begin
        int wait_n;
        int extra;
        void'($urandom(10));
        s_flit        = '0;
        s_valid       = 1'b0;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        back_pressure = 1'b0;
        wait_n        = 0;
        while (rst !== 1'b0 && wait_n < TIMEOUT) begin
            @(posedge clk);
            wait_n++;
        end
        if (rst !== 1'b0) begin
            $display("reset was never released");
            errors++;
        end
        run_test("single flit and non-IPv4", 0, 1, 8, 1'b0);
        run_test("IPv4 TCP", 2, 2, 6, 1'b0);
        run_test("short UDP and other protocols", 3, 4, 8, 1'b0);
        run_test("long UDP split", 5, 5, 6, 1'b0);
        run_test("mixed with back-pressure", 0, 5, 24, 1'b1);
        back_pressure = 1'b0;
        extra         = 0;
        for (wait_n = 0; wait_n < 20; wait_n++) begin
            @(negedge clk);
            if (m_valid || m_cmd_valid) extra++;
        end
        if (extra != 0) begin
            $display("output kept coming after the last expected frame");
            errors++;
        end
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+include
+incdir+tests
logic/tso_pkg.sv
logic/hdr_classify.sv
logic/seg_engine.sv
logic/stream_reg.sv
logic/udp_seg_offload.sv
tests/tb_clock.sv
tests/tb_udp_seg.sv

// File: Makefile
# Verilator build of the testbench; run passes only if the log holds the pass line

BIN  := obj_dir/Vtb_udp_seg
SRCS := $(shell grep '\.sv$$' sim.f)
HDRS := $(wildcard include/*.svh tests/*.svh)

.PHONY: run clean

run: $(BIN)
	$(BIN) | tee sim.log
	grep -q "PASS: all tests" sim.log

$(BIN): sim.f $(SRCS) $(HDRS)
	verilator --binary --timing -f sim.f --top-module tb_udp_seg

clean:
	rm -rf obj_dir sim.log
